/* common/cq_cfg.svh */
`ifndef CQ_CFG_SVH
`define CQ_CFG_SVH

// queue count widths
// a queue with count width n holds 2**n - 1 words
`define CQ_CMD_COUNT_WIDTH 4
`define CQ_RES_COUNT_WIDTH 3

// register byte addresses on the bus
`define CQ_ADDR_CMD 4'h0
`define CQ_ADDR_RESULT 4'h4
`define CQ_ADDR_STATUS 4'h8
`define CQ_ADDR_COMPLETED 4'hC

// status register value with empty queues and no underflow
`define CQ_STATUS_RESET 32'h0000_0000

`endif

/* common/cq_bus_pkg.sv */
package cq_bus_pkg;

    // register byte address, only the low nibble is decoded
    typedef logic [3:0] wb_addr_t;

    // bus data word
    typedef logic [31:0] wb_data_t;

    // slave handshake states
    // idle waits for a request
    // stall holds a command write while the queue is full
    // ack is the single acknowledge cycle
    typedef enum logic [1:0] {
        bus_idle,
        bus_stall,
        bus_ack
    } bus_state_e;

endpackage

/* common/cq_op_pkg.sv */
package cq_op_pkg;

    // command fields
    typedef logic [3:0] opcode_t;
    typedef logic [3:0] tag_t;
    typedef logic [11:0] operand_t;
    typedef logic [15:0] value_t;

    // opcode, tag, operand_a, operand_b from msb down
    typedef logic [31:0] cmd_word_t;
    // tag on top, flags above the 16-bit value
    typedef logic [31:0] result_word_t;

    localparam opcode_t op_add = 4'd0;
    localparam opcode_t op_sub = 4'd1;
    localparam opcode_t op_and = 4'd2;
    localparam opcode_t op_xor = 4'd3;
    localparam opcode_t op_shl = 4'd4;
    localparam opcode_t op_max = 4'd5;

    // flag positions in a result word
    localparam int res_error_bit = 18;
    localparam int res_zero_bit = 17;
    localparam int res_carry_bit = 16;

endpackage

/* queue/fifo.sv */
// circular buffer in block ram, head word always visible on dout
module fifo #(
    parameter int data_width = 32,
    parameter int count_width = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [data_width-1:0]  din,
    input  logic                   wr_en,
    input  logic                   rd_en,
    output logic [data_width-1:0]  dout,
    output logic                   full,
    output logic                   empty,
    output logic [count_width-1:0] data_count
);
    // bit 2 bypass register valid
    // bit 1 ram output register valid
    // bit 0 ram holds the next word but output not loaded yet
    typedef enum logic [2:0] {
        st_none = 3'b000,
        st_byp = 3'b100,
        st_byp_ram = 3'b101,
        st_out = 3'b010,
        st_out_ram = 3'b011,
        st_byp_out = 3'b111
    } fill_state_e;

    fill_state_e state, state_next;
    logic [count_width-1:0] head, head_next, head_inc;
    logic [count_width-1:0] tail, tail_next, tail_inc;
    logic [data_width-1:0] mem [2**count_width];
    logic [data_width-1:0] mem_q;
    logic [data_width-1:0] byp_q, byp_next;
    logic push, pop;

    assign head_inc = head + 1'b1;
    assign tail_inc = tail + 1'b1;
    assign data_count = tail - head;
    assign empty = (head == tail);
    // one slot stays free to tell full from empty
    assign full = (tail_inc == head);

    // drop writes when full and reads when empty
    assign push = wr_en && !full;
    assign pop = rd_en && !empty;
    assign tail_next = push ? tail_inc : tail;
    assign head_next = pop ? head_inc : head;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_none;
            head <= '0;
            tail <= '0;
        end
        else
        begin
            state <= state_next;
            head <= head_next;
            tail <= tail_next;
        end
    end

    // storage and registered read of the word after the head
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[tail] <= din;
        end
        mem_q <= mem[head_inc];
        byp_q <= byp_next;
    end

    always_comb
    begin
        state_next = state;
        byp_next = byp_q;
        dout = byp_q;
        case (state)
            st_none:
            begin
                // first word goes straight into the bypass register
                if (push)
                begin
                    state_next = st_byp;
                    byp_next = din;
                end
            end
            st_byp:
            begin
                case ({push, pop})
                    2'b11: byp_next = din;
                    2'b10: state_next = st_byp_ram;
                    2'b01: state_next = st_none;
                    default: state_next = st_byp;
                endcase
            end
            st_byp_ram:
            begin
                // ram read of the second word lands on this edge
                case ({push, pop})
                    2'b11: state_next = st_out_ram;
                    2'b01: state_next = st_out;
                    default: state_next = st_byp_out;
                endcase
            end
            st_out:
            begin
                dout = mem_q;
                case ({push, pop})
                    2'b11:
                    begin
                        state_next = st_byp;
                        byp_next = din;
                    end
                    2'b10:
                    begin
                        state_next = st_byp_ram;
                        byp_next = mem_q;
                    end
                    2'b01: state_next = st_none;
                    default:
                    begin
                        // mem_q reloads every cycle, park the head word
                        state_next = st_byp;
                        byp_next = mem_q;
                    end
                endcase
            end
            st_out_ram:
            begin
                dout = mem_q;
                case ({push, pop})
                    2'b11: state_next = st_out_ram;
                    2'b01: state_next = (data_count == count_width'(2)) ? st_out : st_out_ram;
                    default:
                    begin
                        state_next = st_byp_out;
                        byp_next = mem_q;
                    end
                endcase
            end
            st_byp_out:
            begin
                if (pop)
                begin
                    byp_next = mem_q;
                    // ram output reloads with the new head word
                    if (data_count == count_width'(2))
                    begin
                        state_next = push ? st_byp_ram : st_byp;
                    end
                    else
                    begin
                        state_next = st_out_ram;
                    end
                end
            end
            default: state_next = st_none;
        endcase
    end

    // count moves by one per accepted write, never wraps past capacity
    assert property (@(posedge clk) disable iff (reset)
        (push && !pop) |=> (int'(data_count) == int'($past(data_count)) + 1));

    // FSM empty state tracks the pointer comparison
    assert property (@(posedge clk) disable iff (reset)
        empty == (state == st_none));

endmodule

/* rtl/wb_reg_decode.sv */
`include "cq_cfg.svh"

// wishbone classic slave for the four registers
module wb_reg_decode (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  cq_bus_pkg::wb_addr_t              adr,
    input  cq_bus_pkg::wb_data_t              dat_w,
    output cq_bus_pkg::wb_data_t              dat_r,
    output logic                              ack,
    output logic                              cmd_wr_en,
    output cq_op_pkg::cmd_word_t              cmd_din,
    input  logic                              cmd_full,
    input  logic [`CQ_CMD_COUNT_WIDTH-1:0]    cmd_count,
    output logic                              res_rd_en,
    input  cq_op_pkg::result_word_t           res_dout,
    input  logic                              res_empty,
    input  logic [`CQ_RES_COUNT_WIDTH-1:0]    res_count,
    input  logic [15:0]                       completed
);
    cq_bus_pkg::bus_state_e state, state_next;
    cq_bus_pkg::wb_data_t status;
    logic req, cmd_write, result_read, underflow;

    assign req = cyc && stb;
    assign cmd_write = we && (adr == `CQ_ADDR_CMD);
    assign result_read = !we && (adr == `CQ_ADDR_RESULT);

    always_comb
    begin
        state_next = state;
        case (state)
            cq_bus_pkg::bus_idle:
            begin
                if (req)
                begin
                    // full command queue holds the write back
                    state_next = (cmd_write && cmd_full) ? cq_bus_pkg::bus_stall
                                                         : cq_bus_pkg::bus_ack;
                end
            end
            cq_bus_pkg::bus_stall:
            begin
                if (!req)
                begin
                    state_next = cq_bus_pkg::bus_idle;
                end
                else if (!cmd_full)
                begin
                    state_next = cq_bus_pkg::bus_ack;
                end
            end
            default: state_next = cq_bus_pkg::bus_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= cq_bus_pkg::bus_idle;
            underflow <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // sticky until reset
            if (ack && result_read && res_empty)
            begin
                underflow <= 1'b1;
            end
        end
    end

    // push and pop both land in the ack cycle
    assign ack = (state == cq_bus_pkg::bus_ack);
    assign cmd_wr_en = ack && cmd_write;
    assign cmd_din = dat_w;
    assign res_rd_en = ack && result_read && !res_empty;

    // read data mux
    always_comb
    begin
        status = `CQ_STATUS_RESET;
        status[`CQ_CMD_COUNT_WIDTH-1:0] = cmd_count;
        status[8 +: `CQ_RES_COUNT_WIDTH] = res_count;
        status[16] = underflow;
        case (adr)
            `CQ_ADDR_RESULT: dat_r = res_empty ? '0 : res_dout;
            `CQ_ADDR_STATUS: dat_r = status;
            `CQ_ADDR_COMPLETED: dat_r = {16'h0000, completed};
            default: dat_r = '0;
        endcase
    end

    // ack only while the master still holds the request
    assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb));

endmodule

/* rtl/cmd_execute.sv */
// pops one command at a time and computes its 16-bit value
module cmd_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  cq_op_pkg::cmd_word_t cmd_dout,
    input  logic                 cmd_empty,
    output logic                 cmd_rd_en,
    input  logic                 ready,
    output logic                 exe_valid,
    output cq_op_pkg::tag_t      exe_tag,
    output cq_op_pkg::value_t    exe_value,
    output logic                 exe_carry,
    output logic                 exe_error
);
    cq_op_pkg::opcode_t opcode;
    cq_op_pkg::operand_t operand_a, operand_b;
    cq_op_pkg::value_t wide_a, wide_b, value;
    logic carry, error;

    // field split
    assign opcode = cmd_dout[31:28];
    assign operand_a = cmd_dout[23:12];
    assign operand_b = cmd_dout[11:0];
    assign wide_a = {4'h0, operand_a};
    assign wide_b = {4'h0, operand_b};

    // writeback has room for one more item
    assign cmd_rd_en = ready && !cmd_empty;

    always_comb
    begin
        value = '0;
        carry = 1'b0;
        error = 1'b0;
        case (opcode)
            cq_op_pkg::op_add:
            begin
                value = wide_a + wide_b;
                carry = value[12];
            end
            cq_op_pkg::op_sub:
            begin
                // bit 12 doubles as borrow
                value = wide_a - wide_b;
                carry = value[12];
            end
            cq_op_pkg::op_and: value = wide_a & wide_b;
            cq_op_pkg::op_xor: value = wide_a ^ wide_b;
            cq_op_pkg::op_shl: value = wide_a << operand_b[3:0];
            cq_op_pkg::op_max: value = (operand_a > operand_b) ? wide_a : wide_b;
            default: error = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exe_valid <= 1'b0;
        end
        else
        begin
            exe_valid <= cmd_rd_en;
        end
    end

    // capture on the pop edge
    always_ff @(posedge clk)
    begin
        if (cmd_rd_en)
        begin
            exe_tag <= cmd_dout[27:24];
            exe_value <= value;
            exe_carry <= carry;
            exe_error <= error;
        end
    end

endmodule

/* rtl/result_writeback.sv */
`include "cq_cfg.svh"

// packs flags and tag, pushes into the result queue
module result_writeback (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           exe_valid,
    input  cq_op_pkg::tag_t                exe_tag,
    input  cq_op_pkg::value_t              exe_value,
    input  logic                           exe_carry,
    input  logic                           exe_error,
    input  logic [`CQ_RES_COUNT_WIDTH-1:0] res_count,
    output logic                           ready,
    output logic                           res_wr_en,
    output cq_op_pkg::result_word_t        res_din,
    output logic [15:0]                    completed
);
    localparam int res_capacity = (1 << `CQ_RES_COUNT_WIDTH) - 1;

    cq_op_pkg::result_word_t packed_word;
    logic [`CQ_RES_COUNT_WIDTH:0] occupancy;
    logic item_valid;

    always_comb
    begin
        packed_word = '0;
        packed_word[31:28] = exe_tag;
        packed_word[cq_op_pkg::res_error_bit] = exe_error;
        packed_word[cq_op_pkg::res_zero_bit] = (exe_value == '0);
        packed_word[cq_op_pkg::res_carry_bit] = exe_carry;
        packed_word[15:0] = exe_value;
    end

    // queued words plus both pipeline slots must fit
    assign occupancy = {1'b0, res_count} + exe_valid + item_valid;
    assign ready = (occupancy < res_capacity);
    assign res_wr_en = item_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            item_valid <= 1'b0;
            completed <= '0;
        end
        else
        begin
            item_valid <= exe_valid;
            if (res_wr_en)
            begin
                completed <= completed + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (exe_valid)
        begin
            res_din <= packed_word;
        end
    end

    // ready accounting keeps the queue from overflowing
    assert property (@(posedge clk) disable iff (reset)
        res_wr_en |-> (res_count < res_capacity));

endmodule

/* rtl/cmd_queue_top.sv */
`include "cq_cfg.svh"

module cmd_queue_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  cq_bus_pkg::wb_addr_t adr,
    input  cq_bus_pkg::wb_data_t dat_w,
    output cq_bus_pkg::wb_data_t dat_r,
    output logic                 ack
);
    // command path
    cq_op_pkg::cmd_word_t cmd_din, cmd_dout;
    logic cmd_wr_en, cmd_rd_en, cmd_full, cmd_empty;
    logic [`CQ_CMD_COUNT_WIDTH-1:0] cmd_count;

    // execute to writeback
    logic exe_valid, exe_carry, exe_error, ready;
    cq_op_pkg::tag_t exe_tag;
    cq_op_pkg::value_t exe_value;

    // result path
    cq_op_pkg::result_word_t res_din, res_dout;
    logic res_wr_en, res_rd_en, res_empty;
    logic [`CQ_RES_COUNT_WIDTH-1:0] res_count;
    logic [15:0] completed;

    wb_reg_decode wb_reg_decode_i (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .cmd_wr_en(cmd_wr_en), .cmd_din(cmd_din),
        .cmd_full(cmd_full), .cmd_count(cmd_count),
        .res_rd_en(res_rd_en), .res_dout(res_dout),
        .res_empty(res_empty), .res_count(res_count),
        .completed(completed)
    );

    fifo #(.data_width(32), .count_width(`CQ_CMD_COUNT_WIDTH)) cmd_queue (
        .clk(clk), .reset(reset),
        .din(cmd_din), .wr_en(cmd_wr_en), .rd_en(cmd_rd_en),
        .dout(cmd_dout), .full(cmd_full), .empty(cmd_empty),
        .data_count(cmd_count)
    );

    cmd_execute cmd_execute_i (
        .clk(clk), .reset(reset),
        .cmd_dout(cmd_dout), .cmd_empty(cmd_empty), .cmd_rd_en(cmd_rd_en),
        .ready(ready), .exe_valid(exe_valid), .exe_tag(exe_tag),
        .exe_value(exe_value), .exe_carry(exe_carry), .exe_error(exe_error)
    );

    result_writeback result_writeback_i (
        .clk(clk), .reset(reset),
        .exe_valid(exe_valid), .exe_tag(exe_tag), .exe_value(exe_value),
        .exe_carry(exe_carry), .exe_error(exe_error),
        .res_count(res_count), .ready(ready),
        .res_wr_en(res_wr_en), .res_din(res_din), .completed(completed)
    );

    // writeback throttles on the count so full is never reached
    fifo #(.data_width(32), .count_width(`CQ_RES_COUNT_WIDTH)) result_queue (
        .clk(clk), .reset(reset),
        .din(res_din), .wr_en(res_wr_en), .rd_en(res_rd_en),
        .dout(res_dout), .full(), .empty(res_empty),
        .data_count(res_count)
    );

endmodule

/* verification/cmd_queue_tb.sv */
`include "cq_cfg.svh"

module cmd_queue_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ack_timeout = 50;
    localparam int poll_timeout = 200;
    localparam string trace_path = "verification/cmd_queue_trace.txt";

    // wishbone side of the DUT
    logic clk;
    logic reset;
    logic cyc;
    logic stb;
    logic we;
    cq_bus_pkg::wb_addr_t adr;
    cq_bus_pkg::wb_data_t dat_w;
    cq_bus_pkg::wb_data_t dat_r;
    logic ack;

    // trace reader state
    int cycle_count = 0;
    int check_count = 0;
    int fd;
    int n;
    logic [31:0] op;
    logic [8*200-1:0] line;
    cq_bus_pkg::wb_addr_t addr;
    cq_bus_pkg::wb_data_t data;
    cq_bus_pkg::wb_data_t expected;
    cq_bus_pkg::wb_data_t mask;
    cq_bus_pkg::wb_data_t value;

    cmd_queue_top cmd_queue_top_i (
        .clk(clk),
        .reset(reset),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack(ack)
    );

    always #5 clk = ~clk;

    // free running count for the poll limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    // first failure ends the run
    task automatic abort_run(input string reason);
        begin
            $display("%s", reason);
            $display("Test failed");
            $fatal(1, "simulation stopped on first error");
        end
    endtask

    function automatic string reg_name(input cq_bus_pkg::wb_addr_t a);
        case (a)
            `CQ_ADDR_CMD: return "CMD";
            `CQ_ADDR_RESULT: return "RESULT";
            `CQ_ADDR_STATUS: return "STATUS";
            `CQ_ADDR_COMPLETED: return "COMPLETED";
            default: return "unmapped";
        endcase
    endfunction

    // result words, tag and flags included
    task automatic check_result(input string name, input cq_op_pkg::result_word_t exp_word,
                                input cq_op_pkg::result_word_t act_word);
        begin
            check_count++;
            if (act_word !== exp_word)
            begin
                abort_run($sformatf("[FAIL] t=%0t %s expected %08h actual %08h",
                                    $time, name, exp_word, act_word));
            end
        end
    endtask

    // status, completed and other plain registers
    task automatic check_reg(input string name, input cq_bus_pkg::wb_data_t exp_word,
                             input cq_bus_pkg::wb_data_t act_word);
        begin
            check_count++;
            if (act_word !== exp_word)
            begin
                abort_run($sformatf("[FAIL] t=%0t %s expected %08h actual %08h",
                                    $time, name, exp_word, act_word));
            end
        end
    endtask

    // one classic cycle, request held until ack
    task automatic bus_access(input logic is_write, input cq_bus_pkg::wb_addr_t a,
                              input cq_bus_pkg::wb_data_t wdata,
                              output cq_bus_pkg::wb_data_t rdata);
        int waited;
        begin
            waited = 0;
            @(posedge clk);
            #1;
            cyc = 1'b1;
            stb = 1'b1;
            we = is_write;
            adr = a;
            dat_w = wdata;
            // ack and dat_r looked at mid-cycle
            @(negedge clk);
            while (!ack)
            begin
                waited++;
                if (waited >= ack_timeout)
                begin
                    abort_run($sformatf("no ack within %0d cycles for a %s of %s",
                                        ack_timeout, is_write ? "write" : "read", reg_name(a)));
                end
                @(negedge clk);
            end
            // only a command write may stall
            if (!(is_write && a == `CQ_ADDR_CMD) && waited != 1)
            begin
                abort_run($sformatf("[FAIL] t=%0t ack latency for %s expected 1 actual %0d",
                                    $time, reg_name(a), waited));
            end
            rdata = dat_r;
            @(posedge clk);
            #1;
            cyc = 1'b0;
            stb = 1'b0;
            we = 1'b0;
            // ack lasts a single cycle
            if (ack !== 1'b0)
            begin
                abort_run($sformatf("[FAIL] t=%0t ack expected 0 actual %b", $time, ack));
            end
        end
    endtask

    // repeated reads until the masked value settles
    task automatic poll_reg(input cq_bus_pkg::wb_addr_t a, input cq_bus_pkg::wb_data_t exp_word,
                            input cq_bus_pkg::wb_data_t m);
        cq_bus_pkg::wb_data_t rd;
        int start;
        begin
            start = cycle_count;
            bus_access(1'b0, a, '0, rd);
            while ((rd & m) !== (exp_word & m))
            begin
                if (cycle_count - start > poll_timeout)
                begin
                    abort_run($sformatf("poll of %s never reached %08h under mask %08h, last %08h",
                                        reg_name(a), exp_word, m, rd));
                end
                bus_access(1'b0, a, '0, rd);
            end
            check_count++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen(trace_path, "r");
        if (fd == 0)
        begin
            abort_run("could not open the trace file");
        end
        // one op letter per line, '#' starts a comment line
        while ($fscanf(fd, "%s", op) == 1)
        begin
            if (op == "#")
            begin
                n = $fgets(line, fd);
            end
            else if (op == "W")
            begin
                n = $fscanf(fd, "%h %h", addr, data);
                if (n != 2)
                begin
                    abort_run("a W line in the trace file lacks its address or data");
                end
                bus_access(1'b1, addr, data, value);
            end
            else if (op == "R")
            begin
                n = $fscanf(fd, "%h %h", addr, expected);
                if (n != 2)
                begin
                    abort_run("an R line in the trace file lacks its address or value");
                end
                bus_access(1'b0, addr, '0, value);
                if (addr == `CQ_ADDR_RESULT)
                begin
                    check_result("dat_r RESULT", expected, value);
                end
                else
                begin
                    check_reg($sformatf("dat_r %s", reg_name(addr)), expected, value);
                end
            end
            else if (op == "P")
            begin
                n = $fscanf(fd, "%h %h %h", addr, expected, mask);
                if (n != 3)
                begin
                    abort_run("a P line in the trace file lacks its address, value or mask");
                end
                poll_reg(addr, expected, mask);
            end
            else
            begin
                abort_run($sformatf("unknown op '%0s' in the trace file", op));
            end
        end
        $fclose(fd);

        if (check_count == 0)
        begin
            abort_run("the trace file held no checks");
        end
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* verification/cmd_queue_trace.txt */
# op addr value [mask], all fields hex
# W writes value, R reads and expects value, P polls until (read & mask) == (value & mask)
# after reset, then an underflow read
R 8 00000000
R C 00000000
R 4 00000000
R 8 00010000
# add, add carry, sub zero, sub borrow, and, xor, shl
W 0 01123456
W 0 02FFF001
W 0 13005005
W 0 14001002
W 0 25F0F0FF
W 0 36ABCABC
W 0 470F3004
P 8 00010700 00010F0F
R 4 10000579
R 4 20011000
R 4 30020000
R 4 4001FFFF
R 4 5000000F
R 4 60020000
R 4 70000F30
# max, shl past 16 bits, unknown opcode
W 0 583007FF
W 0 4980100C
W 0 FA123456
P 8 00010300 00010F0F
R 4 800007FF
R 4 90001000
R 4 A0060000
# ten tagged commands come back in order
W 0 00000100
W 0 01001100
W 0 02002100
W 0 03003100
W 0 04004100
W 0 05005100
W 0 06006100
W 0 07007100
W 0 08008100
W 0 09009100
P 8 00010703 00010F0F
R 4 00000100
R 4 10000101
R 4 20000102
R 4 30000103
R 4 40000104
R 4 50000105
R 4 60000106
P 8 00010300 00010F0F
R 4 70000107
R 4 80000108
R 4 90000109
# back-pressure, twenty writes before any read
W 0 00000200
W 0 01001200
W 0 02002200
W 0 03003200
W 0 04004200
W 0 05005200
W 0 06006200
W 0 07007200
W 0 08008200
W 0 09009200
W 0 0A00A200
W 0 0B00B200
W 0 0C00C200
W 0 0D00D200
W 0 0E00E200
W 0 0F00F200
W 0 00010200
W 0 01011200
W 0 02012200
W 0 03013200
P 8 0001070D 00010F0F
R 4 00000200
R 4 10000201
R 4 20000202
R 4 30000203
R 4 40000204
R 4 50000205
R 4 60000206
R 4 70000207
R 4 80000208
R 4 90000209
P 8 00010703 00010F0F
R 4 A000020A
R 4 B000020B
R 4 C000020C
R 4 D000020D
R 4 E000020E
R 4 F000020F
R 4 00000210
R 4 10000211
R 4 20000212
R 4 30000213
# idle queues, forty commands completed
P 8 00010000 00010F0F
R C 00000028

/* cmd_queue_top.f */
+incdir+common
common/cq_bus_pkg.sv
common/cq_op_pkg.sv
queue/fifo.sv
rtl/wb_reg_decode.sv
rtl/cmd_execute.sv
rtl/result_writeback.sv
rtl/cmd_queue_top.sv
verification/cmd_queue_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with verilator and runs it from the project root
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cmd_queue_tb -Mdir obj_dir -f cmd_queue_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcmd_queue_tb
if [ $? -ne 0 ]; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0
